//--- logic/lsu_pkg.sv
package lsu_pkg;

    // ************************************************************
    // load/store data path
    // ************************************************************

    // one bus word, one strobe bit per byte
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // access size as the client encodes it
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_e;

endpackage

//--- logic/mem_pkg.sv
package mem_pkg;

    // ************************************************************
    // address map and cache geometry
    // ************************************************************

    localparam int ADDR_W = 32;

    // cacheable window, both ends inclusive
    localparam logic [ADDR_W-1:0] CACHE_BASE  = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] CACHE_LIMIT = 32'h8800_0000;

    // byte offset inside one 64-bit word
    localparam int OFFSET_W = 3;

    localparam int DEFAULT_INDEX_W = 4;
    localparam int DEFAULT_TAG_W   = ADDR_W - DEFAULT_INDEX_W - OFFSET_W;
    localparam int WORD_ADDR_W     = ADDR_W - OFFSET_W;

    // cache view, laid out for the default line count
    typedef struct packed {
        logic [DEFAULT_TAG_W-1:0]   tag;
        logic [DEFAULT_INDEX_W-1:0] index;
        logic [OFFSET_W-1:0]        offset;
    } cache_view_t;

    typedef struct packed {
        logic [WORD_ADDR_W-1:0] word;
        logic [OFFSET_W-1:0]    offset;
    } word_view_t;

    typedef union packed {
        cache_view_t cache;
        word_view_t  word;
    } mem_addr_u;

endpackage

//--- logic/mem_req_if.sv
interface mem_req_if;
    import lsu_pkg::*;
    import mem_pkg::*;

    // four-phase req/ack, one word per transfer
    logic              req;
    logic              ack;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] rdata;

    modport requester (
        output req, we, addr, wdata, wstrb,
        input  ack, rdata
    );

    modport responder (
        input  req, we, addr, wdata, wstrb,
        output ack, rdata
    );

endinterface

//--- logic/lsu_align.sv
module lsu_align (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  logic                        we_i,
    input  lsu_pkg::access_size_e       size_i,
    input  logic                        unsigned_i,
    input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata_i,
    output logic                        ack_o,
    output logic [lsu_pkg::DATA_W-1:0]  rdata_o,
    mem_req_if.requester                link_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LINK,
        HOLD
    } state_e;

    state_e              state_q;
    mem_addr_u           addr_in;
    access_size_e        size_q;
    logic                unsigned_q;
    logic [OFFSET_W-1:0] offset_q;
    logic [STRB_W-1:0]   size_strb;
    logic [DATA_W-1:0]   lane;
    logic [DATA_W-1:0]   load_ext;

    assign addr_in = addr_i;

    // ************************************************************
    // store side: strobe and lane shift
    // ************************************************************
    always_comb begin
        case (size_i)
            SIZE_B:  size_strb = STRB_W'(8'h01);
            SIZE_H:  size_strb = STRB_W'(8'h03);
            SIZE_W:  size_strb = STRB_W'(8'h0f);
            default: size_strb = '1;
        endcase
    end

    // ************************************************************
    // load side: pick lanes, then extend
    // ************************************************************
    always_comb begin
        lane = link_o.rdata >> {offset_q, 3'b000};
        case (size_q)
            SIZE_B:  load_ext = {{(DATA_W-8){lane[7] & ~unsigned_q}}, lane[7:0]};
            SIZE_H:  load_ext = {{(DATA_W-16){lane[15] & ~unsigned_q}}, lane[15:0]};
            SIZE_W:  load_ext = {{(DATA_W-32){lane[31] & ~unsigned_q}}, lane[31:0]};
            default: load_ext = lane;
        endcase
    end

    // client handshake and link request
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            link_o.req <= 1'b0;
            ack_o      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        link_o.req <= 1'b1;
                        state_q    <= WAIT_LINK;
                    end
                end
                WAIT_LINK: begin
                    if (link_o.ack) begin
                        link_o.req <= 1'b0;
                        ack_o      <= 1'b1;
                        state_q    <= HOLD;
                    end
                end
                HOLD: begin
                    // link must be back to idle before the next access
                    if (!req_i && !link_o.ack) begin
                        ack_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            size_q       <= size_i;
            unsigned_q   <= unsigned_i;
            offset_q     <= addr_in.word.offset;
            link_o.we    <= we_i;
            link_o.addr  <= {addr_in.word.word, {OFFSET_W{1'b0}}};
            link_o.wdata <= wdata_i << {addr_in.word.offset, 3'b000};
            link_o.wstrb <= size_strb << addr_in.word.offset;
        end
        if (state_q == WAIT_LINK && link_o.ack) begin
            rdata_o <= load_ext;
        end
    end

endmodule

//--- logic/dcache_wt.sv
module dcache_wt #(
    parameter int INDEX_W = mem_pkg::DEFAULT_INDEX_W
) (
    input  logic         clk,
    input  logic         arst_n_i,
    mem_req_if.responder link_i,
    mem_req_if.requester link_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int LINES = 2 ** INDEX_W;
    localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MEM,
        HOLD
    } state_e;

    state_e             state_q;
    mem_addr_u          addr_in;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               cacheable;
    logic               hit;
    logic               load_hit;
    logic               mem_done;
    logic [DATA_W-1:0]  merged;
    logic [LINES-1:0]   valid_q;
    logic [TAG_W-1:0]   tag_q [LINES];
    logic [DATA_W-1:0]  data_q [LINES];

    // ************************************************************
    // lookup
    // ************************************************************
    assign addr_in = link_i.addr;
    assign index   = addr_in.word.word[INDEX_W-1:0];
    assign tag     = addr_in.word.word[WORD_ADDR_W-1:INDEX_W];

    assign cacheable = (link_i.addr >= CACHE_BASE) && (link_i.addr <= CACHE_LIMIT);
    assign hit       = cacheable && valid_q[index] && (tag_q[index] == tag);
    assign load_hit  = link_i.req && !link_i.we && hit;
    assign mem_done  = (state_q == WAIT_MEM) && link_o.ack;

    // requester holds its fields while req is up
    assign link_o.we    = link_i.we;
    assign link_o.addr  = link_i.addr;
    assign link_o.wdata = link_i.wdata;
    assign link_o.wstrb = link_i.wstrb;

    // store data merged into the resident line
    always_comb begin
        merged = data_q[index];
        for (int b = 0; b < STRB_W; b++) begin
            if (link_i.wstrb[b]) begin
                merged[b*8 +: 8] = link_i.wdata[b*8 +: 8];
            end
        end
    end

    // ************************************************************
    // control
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            link_i.ack <= 1'b0;
            link_o.req <= 1'b0;
            valid_q    <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (load_hit) begin
                        link_i.ack <= 1'b1;
                        state_q    <= HOLD;
                    end else if (link_i.req) begin
                        link_o.req <= 1'b1;
                        state_q    <= WAIT_MEM;
                    end
                end
                WAIT_MEM: begin
                    if (link_o.ack) begin
                        link_o.req <= 1'b0;
                        link_i.ack <= 1'b1;
                        state_q    <= HOLD;
                        if (cacheable && !link_i.we) begin
                            valid_q[index] <= 1'b1;
                        end
                    end
                end
                HOLD: begin
                    if (!link_i.req && !link_o.ack) begin
                        link_i.ack <= 1'b0;
                        state_q    <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // line arrays and returned word
    always_ff @(posedge clk) begin
        if (state_q == IDLE && load_hit) begin
            link_i.rdata <= data_q[index];
        end
        if (mem_done) begin
            link_i.rdata <= link_o.rdata;
            if (cacheable && !link_i.we) begin
                tag_q[index]  <= tag;
                data_q[index] <= link_o.rdata;
            end else if (hit && link_i.we) begin
                data_q[index] <= merged;
            end
        end
    end

endmodule

//--- logic/mem_port.sv
module mem_port (
    input  logic                        clk,
    input  logic                        arst_n_i,
    mem_req_if.responder                link_i,
    output logic                        mem_req_o,
    output logic                        mem_we_o,
    output logic [mem_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [lsu_pkg::DATA_W-1:0]  mem_wdata_o,
    output logic [lsu_pkg::STRB_W-1:0]  mem_wstrb_o,
    input  logic                        mem_ack_i,
    input  logic [lsu_pkg::DATA_W-1:0]  mem_rdata_i
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        HOLD
    } state_e;

    state_e    state_q;
    mem_addr_u addr_in;

    assign addr_in = link_i.addr;

    // ************************************************************
    // external four-phase sequence
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            mem_req_o  <= 1'b0;
            link_i.ack <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (link_i.req) begin
                        mem_req_o <= 1'b1;
                        state_q   <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (mem_ack_i) begin
                        mem_req_o  <= 1'b0;
                        link_i.ack <= 1'b1;
                        state_q    <= HOLD;
                    end
                end
                HOLD: begin
                    if (!link_i.req && !mem_ack_i) begin
                        link_i.ack <= 1'b0;
                        state_q    <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // bus fields and read data
    always_ff @(posedge clk) begin
        if (state_q == IDLE && link_i.req) begin
            mem_we_o    <= link_i.we;
            mem_addr_o  <= {addr_in.word.word, {OFFSET_W{1'b0}}};
            mem_wdata_o <= link_i.wdata;
            mem_wstrb_o <= link_i.wstrb;
        end
        if (state_q == WAIT_ACK && mem_ack_i) begin
            link_i.rdata <= mem_rdata_i;
        end
    end

endmodule

//--- logic/dmem_top.sv
module dmem_top #(
    parameter int INDEX_W = mem_pkg::DEFAULT_INDEX_W
) (
    input  logic                        clk,
    input  logic                        arst_n_i,

    // client side
    input  logic                        req_i,
    input  logic                        we_i,
    input  lsu_pkg::access_size_e       size_i,
    input  logic                        unsigned_i,
    input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata_i,
    output logic                        ack_o,
    output logic [lsu_pkg::DATA_W-1:0]  rdata_o,

    // external memory
    output logic                        mem_req_o,
    output logic                        mem_we_o,
    output logic [mem_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [lsu_pkg::DATA_W-1:0]  mem_wdata_o,
    output logic [lsu_pkg::STRB_W-1:0]  mem_wstrb_o,
    input  logic                        mem_ack_i,
    input  logic [lsu_pkg::DATA_W-1:0]  mem_rdata_i
);

    mem_req_if link_cache ();
    mem_req_if link_mem ();

    lsu_align lsu_align_i (
        .clk        ( clk        ),
        .arst_n_i   ( arst_n_i   ),
        .req_i      ( req_i      ),
        .we_i       ( we_i       ),
        .size_i     ( size_i     ),
        .unsigned_i ( unsigned_i ),
        .addr_i     ( addr_i     ),
        .wdata_i    ( wdata_i    ),
        .ack_o      ( ack_o      ),
        .rdata_o    ( rdata_o    ),
        .link_o     ( link_cache )
    );

    dcache_wt #(
        .INDEX_W ( INDEX_W )
    ) dcache_wt_i (
        .clk      ( clk        ),
        .arst_n_i ( arst_n_i   ),
        .link_i   ( link_cache ),
        .link_o   ( link_mem   )
    );

    mem_port mem_port_i (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .link_i      ( link_mem    ),
        .mem_req_o   ( mem_req_o   ),
        .mem_we_o    ( mem_we_o    ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_wstrb_o ( mem_wstrb_o ),
        .mem_ack_i   ( mem_ack_i   ),
        .mem_rdata_i ( mem_rdata_i )
    );

endmodule

//--- bench/sim_memory.sv
module sim_memory (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [mem_pkg::ADDR_W-1:0] addr_i,
    input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
    input  logic [lsu_pkg::STRB_W-1:0] wstrb_i,
    output logic                       ack_o,
    output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
    localparam logic [31:0] SEED = 32'd90979;

    logic [63:0] words [logic [31:0]];
    logic [31:0] delay_state;
    logic [31:0] word_addr;
    logic [63:0] data;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // initial content, mixed from the whole word address
    function automatic logic [63:0] word_init(input logic [31:0] wa);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg(lcg(SEED ^ wa));
        lo = lcg(hi);
        return {hi, lo};
    endfunction

    function automatic logic [63:0] peek(input logic [31:0] wa);
        if (words.exists(wa)) begin
            return words[wa];
        end
        return word_init(wa);
    endfunction

    initial begin
        ack_o       = 1'b0;
        rdata_o     = '0;
        delay_state = SEED;
    end

    // ************************************************************
    // four-phase responder, driven on the falling edge
    // ************************************************************
    always begin
        @(negedge clk);
        if (arst_n_i && req_i) begin
            delay_state = lcg(delay_state);
            repeat (delay_state[17:16]) @(negedge clk);
            word_addr = addr_i >> 3;
            data      = peek(word_addr);
            if (we_i) begin
                for (int b = 0; b < 8; b++) begin
                    if (wstrb_i[b]) begin
                        data[b*8 +: 8] = wdata_i[b*8 +: 8];
                    end
                end
                words[word_addr] = data;
            end
            rdata_o = data;
            ack_o   = 1'b1;
            while (req_i) begin
                @(negedge clk);
            end
            ack_o = 1'b0;
        end
    end

endmodule

//--- bench/tb_dmem.sv
module tb_dmem;
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int ACK_LIMIT = 40;

    localparam logic [31:0] A = 32'h8000_0100;
    localparam logic [31:0] B = 32'h8000_0180;  // same index as A
    localparam logic [31:0] C = 32'h8000_0208;
    localparam logic [31:0] L = 32'h8800_0000;
    localparam logic [31:0] U = 32'h1000_0040;
    localparam logic [31:0] H = 32'h9000_0008;

    typedef struct {
        logic         we;
        access_size_e size;
        logic         uns;
        logic [31:0]  addr;
        logic [63:0]  wdata;
        logic [63:0]  rdata;
        int           reqs;
    } row_t;

    logic              clk;
    logic              arst_n_i;
    logic              req_i;
    logic              we_i;
    access_size_e      size_i;
    logic              unsigned_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic              ack_o;
    logic [DATA_W-1:0] rdata_o;
    logic              mem_req_o;
    logic              mem_we_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic [DATA_W-1:0] mem_wdata_o;
    logic [STRB_W-1:0] mem_wstrb_o;
    logic              mem_ack_i;
    logic [DATA_W-1:0] mem_rdata_i;

    row_t        rows[$];
    logic [63:0] shadow [logic [31:0]];
    int          mem_req_total = 0;
    logic        mem_req_prev = 1'b0;
    logic        table_ready;

    always #5 clk = ~clk;

    dmem_top dmem_top_i (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .req_i       ( req_i       ),
        .we_i        ( we_i        ),
        .size_i      ( size_i      ),
        .unsigned_i  ( unsigned_i  ),
        .addr_i      ( addr_i      ),
        .wdata_i     ( wdata_i     ),
        .ack_o       ( ack_o       ),
        .rdata_o     ( rdata_o     ),
        .mem_req_o   ( mem_req_o   ),
        .mem_we_o    ( mem_we_o    ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_wstrb_o ( mem_wstrb_o ),
        .mem_ack_i   ( mem_ack_i   ),
        .mem_rdata_i ( mem_rdata_i )
    );

    sim_memory mem_model_i (
        .clk      ( clk         ),
        .arst_n_i ( arst_n_i    ),
        .req_i    ( mem_req_o   ),
        .we_i     ( mem_we_o    ),
        .addr_i   ( mem_addr_o  ),
        .wdata_i  ( mem_wdata_o ),
        .wstrb_i  ( mem_wstrb_o ),
        .ack_o    ( mem_ack_i   ),
        .rdata_o  ( mem_rdata_i )
    );

    // rising edges of mem_req_o
    always @(negedge clk) begin
        if (mem_req_o === 1'b1 && !mem_req_prev) begin
            mem_req_total++;
        end
        mem_req_prev = (mem_req_o === 1'b1);
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [63:0] shadow_word(input logic [31:0] wa);
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return mem_model_i.word_init(wa);
    endfunction

    // ************************************************************
    // stimulus table with reference results
    // ************************************************************
    task automatic add_row(input logic we, input access_size_e size, input logic uns,
                           input logic [31:0] addr, input logic [63:0] wdata, input int reqs);
        row_t        r;
        logic [63:0] word;
        int          nbits;
        int          lo;
        word  = shadow_word(addr >> 3);
        nbits = 8 << int'(size);
        lo    = int'(addr[2:0]) * 8;
        r.we    = we;
        r.size  = size;
        r.uns   = uns;
        r.addr  = addr;
        r.wdata = wdata;
        r.reqs  = reqs;
        r.rdata = '0;
        for (int i = 0; i < 64; i++) begin
            if (we && i >= lo && i < lo + nbits) begin
                word[i] = wdata[i - lo];
            end else if (!we && i < nbits) begin
                r.rdata[i] = word[lo + i];
            end else if (!we && !uns) begin
                r.rdata[i] = word[lo + nbits - 1];
            end
        end
        if (we) begin
            shadow[addr >> 3] = word;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(0, SIZE_D, 0, L, 0, 1);
        add_row(0, SIZE_D, 0, L, 0, 0);
        add_row(0, SIZE_D, 0, A, 0, 1);
        add_row(0, SIZE_D, 0, A, 0, 0);
        add_row(0, SIZE_D, 0, U, 0, 1);
        add_row(0, SIZE_D, 0, U, 0, 1);
        add_row(0, SIZE_W, 0, H, 0, 1);
        add_row(0, SIZE_W, 0, H, 0, 1);
        // stores into the resident line of A
        add_row(1, SIZE_B, 0, A + 3, 64'ha5, 1);
        add_row(1, SIZE_H, 0, A + 6, 64'h8001, 1);
        add_row(0, SIZE_D, 0, A, 0, 0);
        add_row(0, SIZE_B, 0, A + 3, 0, 0);
        add_row(0, SIZE_B, 1, A + 3, 0, 0);
        add_row(0, SIZE_H, 0, A + 6, 0, 0);
        add_row(0, SIZE_H, 1, A + 6, 0, 0);
        add_row(0, SIZE_W, 0, A + 4, 0, 0);
        add_row(0, SIZE_W, 1, A, 0, 0);
        add_row(0, SIZE_W, 0, C, 0, 1);
        add_row(0, SIZE_B, 0, C + 7, 0, 0);
        add_row(0, SIZE_H, 1, C + 2, 0, 0);
        // A and B fight over one line
        add_row(0, SIZE_D, 0, B, 0, 1);
        add_row(0, SIZE_D, 0, A, 0, 1);
        add_row(0, SIZE_D, 0, B, 0, 1);
        add_row(0, SIZE_D, 0, A, 0, 1);
        add_row(1, SIZE_W, 0, B + 4, 64'hdead_beef, 1);
        add_row(0, SIZE_D, 0, B, 0, 1);
        add_row(0, SIZE_W, 0, B + 4, 0, 0);
        add_row(1, SIZE_D, 0, U, 64'hfedc_ba98_7654_3210, 1);
        add_row(0, SIZE_H, 0, U + 6, 0, 1);
        add_row(0, SIZE_B, 1, U + 1, 0, 1);
    endtask

    task automatic run_row(input int n);
        row_t r;
        int   start;
        int   waited;
        r = rows[n];
        @(negedge clk);
        we_i       = r.we;
        size_i     = r.size;
        unsigned_i = r.uns;
        addr_i     = r.addr;
        wdata_i    = r.wdata;
        req_i      = 1'b1;
        start      = mem_req_total;
        waited     = 0;
        while (ack_o !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack_o !== 1'b1) begin
            $display("row %0d: no acknowledge from the DUT", n);
            abort_run();
        end
        if (!r.we) begin
            check_value($sformatf("rdata_o (row %0d)", n), rdata_o, r.rdata);
        end
        check_value($sformatf("mem_req_o count (row %0d)", n), mem_req_total - start, r.reqs);
        // ack stays up while the client holds req
        @(negedge clk);
        check_value("ack_o", ack_o, 1);
        req_i  = 1'b0;
        waited = 0;
        while (ack_o !== 1'b0 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack_o !== 1'b0) begin
            $display("row %0d: acknowledge never dropped", n);
            abort_run();
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (rows.size() * 40 + 10) @(posedge clk);
        $display("watchdog: run took longer than %0d cycles", rows.size() * 40 + 10);
        abort_run();
    end

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        size_i      = SIZE_D;
        unsigned_i  = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        check_value("ack_o", ack_o, 0);
        check_value("mem_req_o", mem_req_o, 0);
        for (int n = 0; n < rows.size(); n++) begin
            run_row(n);
        end
        // memory side must match the reference after all stores
        foreach (shadow[k]) begin
            check_value($sformatf("memory word 0x%h", k << 3), mem_model_i.peek(k), shadow[k]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- list.f
logic/lsu_pkg.sv
logic/mem_pkg.sv
logic/mem_req_if.sv
logic/lsu_align.sv
logic/dcache_wt.sv
logic/mem_port.sv
logic/dmem_top.sv
bench/sim_memory.sv
bench/tb_dmem.sv
